// ==== Makefile ====
# Verilator flow for the accumulator processor

TOP := bip_cpu_tb

.PHONY: all lint sim clean

all: sim

# Static checks over RTL and testbench
lint:
	verilator --lint-only --timing --timescale 1ns/1ns \
		-f all.f --top-module $(TOP)

# Build and run, pass only when the pass line appears in the output
sim:
	verilator --binary --timing --timescale 1ns/1ns \
		-f all.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | awk '{ print } /All tests passed!/ { ok = 1 } END { exit !ok }'

# Remove build products
clean:
	rm -rf obj_dir

// ==== all.f ====
logic/bip_pkg.sv
logic/instruction_decoder.sv
logic/control.sv
logic/datapath.sv
logic/program_memory.sv
logic/data_memory.sv
logic/bip_cpu.sv
testbench/bip_cpu_tb.sv

// ==== logic/bip_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module bip_cpu import bip_pkg::*; (
    input  logic               i_clk,
    input  logic               i_rst,
    // Program load port
    input  logic               i_prog_we,
    input  logic [NB_ADDR-1:0] i_prog_addr,
    input  instr_t             i_prog_data,
    // Observation
    output logic [NB_ADDR-1:0] o_pc,
    output logic [NB_DATA-1:0] o_acc,
    output logic               o_halt
);

    instr_t                instr;
    logic [NB_ADDR-1:0]    pc;
    logic [NB_OPERAND-1:0] operand;
    ctrl_t                 ctrl;
    logic [NB_DATA-1:0]    acc;
    logic [NB_DATA-1:0]    mem_data;

    ////////////////////////////////////////////////////////////////////////////
    // Control and datapath
    ////////////////////////////////////////////////////////////////////////////

    control u_control (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_instr   (instr),
        .o_pc      (pc),
        .o_operand (operand),
        .o_ctrl    (ctrl),
        .o_halt    (o_halt)
    );

    // Operand doubles as immediate and data address
    datapath u_datapath (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_ctrl     (ctrl),
        .i_operand  (operand),
        .i_mem_data (mem_data),
        .o_acc      (acc)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memories
    ////////////////////////////////////////////////////////////////////////////

    program_memory u_program_memory (
        .i_clk   (i_clk),
        .i_we    (i_prog_we),
        .i_waddr (i_prog_addr),
        .i_wdata (i_prog_data),
        .i_raddr (pc),
        .o_rdata (instr)
    );

    data_memory u_data_memory (
        .i_clk   (i_clk),
        .i_ctrl  (ctrl),
        .i_addr  (operand),
        .i_wdata (acc),
        .o_rdata (mem_data)
    );

    assign o_pc  = pc;
    assign o_acc = acc;

endmodule

`default_nettype wire

// ==== logic/bip_pkg.sv ====
`default_nettype none

package bip_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and depths
    ////////////////////////////////////////////////////////////////////////////

    // Instruction format
    localparam int NB_INSTR   = 16;
    localparam int NB_OPCODE  = 5;
    localparam int NB_OPERAND = 11;

    // Shared by program and data memory
    localparam int NB_ADDR    = 11;
    localparam int NB_DATA    = 16;

    // Words in each memory
    localparam int PROG_DEPTH = 2048;
    localparam int DATA_DEPTH = 2048;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoding
    ////////////////////////////////////////////////////////////////////////////

    // Codes 8 to 31 are left unnamed and stop the machine like HLT
    typedef enum logic [NB_OPCODE-1:0] {
        HLT  = 5'd0,
        STO  = 5'd1,
        LD   = 5'd2,
        LDI  = 5'd3,
        ADD  = 5'd4,
        ADDI = 5'd5,
        SUB  = 5'd6,
        SUBI = 5'd7
    } opcode_e;

    // Opcode in the upper bits, operand below
    typedef struct packed {
        opcode_e                 opcode;
        logic [NB_OPERAND-1:0]   operand;
    } instr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Control levels
    ////////////////////////////////////////////////////////////////////////////

    // Source of the next accumulator value
    typedef enum logic [1:0] {
        SEL_A_MEM = 2'd0,
        SEL_A_IMM = 2'd1,
        SEL_A_ALU = 2'd2
    } sel_a_e;

    // Decoder output bundle, 7 bits
    typedef struct packed {
        sel_a_e  sel_a;
        logic    sel_b;     // 0 memory word, 1 immediate
        logic    wr_acc;
        logic    op;        // 0 add, 1 subtract
        logic    wr_ram;
        logic    rd_ram;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== logic/control.sv ====
`timescale 1ns/1ns
`default_nettype none

module control import bip_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  instr_t                i_instr,
    output logic [NB_ADDR-1:0]    o_pc,
    output logic [NB_OPERAND-1:0] o_operand,
    output ctrl_t                 o_ctrl,
    output logic                  o_halt
);

    opcode_e              opcode;
    logic                 wr_pc;
    logic [NB_ADDR-1:0]   pc;

    // Field split of the fetched word
    assign opcode    = i_instr.opcode;
    assign o_operand = i_instr.operand;

    ////////////////////////////////////////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            pc <= '0;
        end else if (wr_pc) begin
            pc <= pc + 1'b1;
        end
    end

    assign o_pc = pc;

    // Decoder withholds wr_pc only on HLT or unknown codes once out of reset
    assign o_halt = i_rst && !wr_pc;

    ////////////////////////////////////////////////////////////////////////////
    // Decoder
    ////////////////////////////////////////////////////////////////////////////

    instruction_decoder u_instruction_decoder (
        .i_rst    (i_rst),
        .i_opcode (opcode),
        .o_wr_pc  (wr_pc),
        .o_ctrl   (o_ctrl)
    );

endmodule

`default_nettype wire

// ==== logic/data_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_memory import bip_pkg::*; (
    input  logic               i_clk,
    input  ctrl_t              i_ctrl,
    input  logic [NB_ADDR-1:0] i_addr,
    input  logic [NB_DATA-1:0] i_wdata,
    output logic [NB_DATA-1:0] o_rdata
);

    ////////////////////////////////////////////////////////////////////////////
    // Data store
    ////////////////////////////////////////////////////////////////////////////

    logic [NB_DATA-1:0] mem [DATA_DEPTH];

    // STO writes the accumulator at the operand address
    always_ff @(posedge i_clk) begin
        if (i_ctrl.wr_ram) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // Read data only driven on LD/ADD/SUB, zero otherwise
    assign o_rdata = i_ctrl.rd_ram ? mem[i_addr] : '0;

endmodule

`default_nettype wire

// ==== logic/datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module datapath import bip_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  ctrl_t                 i_ctrl,
    input  logic [NB_OPERAND-1:0] i_operand,
    input  logic [NB_DATA-1:0]    i_mem_data,
    output logic [NB_DATA-1:0]    o_acc
);

    logic [NB_DATA-1:0] imm_ext;
    logic [NB_DATA-1:0] alu_b;
    logic [NB_DATA-1:0] alu_res;
    logic [NB_DATA-1:0] acc_next;
    logic [NB_DATA-1:0] acc;

    ////////////////////////////////////////////////////////////////////////////
    // Operand path
    ////////////////////////////////////////////////////////////////////////////

    // Replicate operand MSB up to data width
    assign imm_ext = {{(NB_DATA-NB_OPERAND){i_operand[NB_OPERAND-1]}}, i_operand};

    // Second ALU input
    assign alu_b = i_ctrl.sel_b ? imm_ext : i_mem_data;

    ////////////////////////////////////////////////////////////////////////////
    // Add/subtract unit
    ////////////////////////////////////////////////////////////////////////////

    // Carry out dropped, result wraps mod 2^16
    always_comb begin
        if (i_ctrl.op) begin
            alu_res = acc - alu_b;
        end else begin
            alu_res = acc + alu_b;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Accumulator
    ////////////////////////////////////////////////////////////////////////////

    // Source mux for the next accumulator value
    always_comb begin
        case (i_ctrl.sel_a)
            SEL_A_MEM: acc_next = i_mem_data;
            SEL_A_IMM: acc_next = imm_ext;
            SEL_A_ALU: acc_next = alu_res;
            // Unused selector code, hold
            default:   acc_next = acc;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            acc <= '0;
        end else if (i_ctrl.wr_acc) begin
            acc <= acc_next;
        end
    end

    // Feeds data memory write data and the top-level port
    assign o_acc = acc;

endmodule

`default_nettype wire

// ==== logic/instruction_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instruction_decoder import bip_pkg::*; (
    input  logic    i_rst,
    input  opcode_e i_opcode,
    output logic    o_wr_pc,
    output ctrl_t   o_ctrl
);

    ////////////////////////////////////////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Everything idle unless an opcode asks for it
        o_wr_pc       = 1'b0;
        o_ctrl.sel_a  = SEL_A_MEM;
        o_ctrl.sel_b  = 1'b0;
        o_ctrl.wr_acc = 1'b0;
        o_ctrl.op     = 1'b0;
        o_ctrl.wr_ram = 1'b0;
        o_ctrl.rd_ram = 1'b0;

        // Reset is active low, nothing moves while it is held
        if (i_rst) begin
            case (i_opcode)
                // Accumulator into memory at operand address
                STO: begin
                    o_wr_pc       = 1'b1;
                    o_ctrl.wr_ram = 1'b1;
                end
                // Memory word into accumulator
                LD: begin
                    o_wr_pc       = 1'b1;
                    o_ctrl.sel_a  = SEL_A_MEM;
                    o_ctrl.wr_acc = 1'b1;
                    o_ctrl.rd_ram = 1'b1;
                end
                // Sign-extended operand into accumulator
                LDI: begin
                    o_wr_pc       = 1'b1;
                    o_ctrl.sel_a  = SEL_A_IMM;
                    o_ctrl.wr_acc = 1'b1;
                end
                // ALU ops, memory or immediate second operand
                ADD, SUB: begin
                    o_wr_pc       = 1'b1;
                    o_ctrl.sel_a  = SEL_A_ALU;
                    o_ctrl.sel_b  = 1'b0;
                    o_ctrl.wr_acc = 1'b1;
                    o_ctrl.op     = (i_opcode == SUB);
                    o_ctrl.rd_ram = 1'b1;
                end
                ADDI, SUBI: begin
                    o_wr_pc       = 1'b1;
                    o_ctrl.sel_a  = SEL_A_ALU;
                    o_ctrl.sel_b  = 1'b1;
                    o_ctrl.wr_acc = 1'b1;
                    o_ctrl.op     = (i_opcode == SUBI);
                end
                // HLT and unknown codes keep the defaults, PC frozen
                default: begin
                    o_wr_pc = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/program_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module program_memory import bip_pkg::*; (
    input  logic               i_clk,
    input  logic               i_we,
    input  logic [NB_ADDR-1:0] i_waddr,
    input  instr_t             i_wdata,
    input  logic [NB_ADDR-1:0] i_raddr,
    output instr_t             o_rdata
);

    ////////////////////////////////////////////////////////////////////////////
    // Instruction store
    ////////////////////////////////////////////////////////////////////////////

    // One instruction per word
    instr_t mem [PROG_DEPTH];

    // Load port, used by the host while the core sits in reset
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Fetch is combinational so decode happens in the same cycle
    assign o_rdata = mem[i_raddr];

endmodule

`default_nettype wire

// ==== testbench/bip_cpu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module bip_cpu_tb import bip_pkg::*; ();

    logic               i_clk;
    logic               i_rst;
    logic               i_prog_we;
    logic [NB_ADDR-1:0] i_prog_addr;
    instr_t             i_prog_data;
    logic [NB_ADDR-1:0] o_pc;
    logic [NB_DATA-1:0] o_acc;
    logic               o_halt;

    // Program under test with one word per entry
    instr_t             prog [$];
    // Reference state of the processor
    logic [NB_DATA-1:0] model_acc;
    logic [NB_DATA-1:0] model_mem [DATA_DEPTH];
    int                 seed;

    bip_cpu DUT (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_prog_we   (i_prog_we),
        .i_prog_addr (i_prog_addr),
        .i_prog_data (i_prog_data),
        .o_pc        (o_pc),
        .o_acc       (o_acc),
        .o_halt      (o_halt)
    );

    // 20 ns clock
    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic instr_t encode(input opcode_e op, input logic [NB_OPERAND-1:0] operand);
        instr_t word;
        word.opcode  = op;
        word.operand = operand;
        return word;
    endfunction

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [NB_DATA-1:0] expected,
                               input logic [NB_DATA-1:0] actual);
        assert (actual === expected) else begin
            $display("ERROR at %0t ns: %s expected 0x%04h, got 0x%04h",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    // One instruction applied to the reference state
    task automatic model_exec(input instr_t ins);
        logic [NB_DATA-1:0] imm;
        logic [NB_DATA-1:0] word;
        // Signed operand widened to data width
        imm  = NB_DATA'($signed(ins.operand));
        word = model_mem[ins.operand];
        case (ins.opcode)
            STO:     model_mem[ins.operand] = model_acc;
            LD:      model_acc = word;
            LDI:     model_acc = imm;
            ADD:     model_acc = model_acc + word;
            ADDI:    model_acc = model_acc + imm;
            SUB:     model_acc = model_acc - word;
            SUBI:    model_acc = model_acc - imm;
            default: model_acc = model_acc;
        endcase
    endtask

    // Whole program up to the first HLT
    task automatic model_program();
        for (int i = 0; i < prog.size(); i++) begin
            if (prog[i].opcode == HLT) begin
                break;
            end
            model_exec(prog[i]);
        end
    endtask

    // Reset held for 10 cycles with data memory left intact
    task automatic enter_reset();
        @(negedge i_clk);
        i_rst = 1'b0;
        repeat (10) @(negedge i_clk);
        model_acc = '0;
    endtask

    // Program written through the load port while reset is low
    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge i_clk);
            i_prog_we   = 1'b1;
            i_prog_addr = NB_ADDR'(i);
            i_prog_data = prog[i];
        end
        @(negedge i_clk);
        i_prog_we = 1'b0;
    endtask

    // Release reset and wait for the core to stop
    task automatic run_program();
        int cycles;
        cycles = 0;
        @(negedge i_clk);
        i_rst = 1'b1;
        do begin
            @(negedge i_clk);
            cycles++;
            if (cycles > 200) begin
                $display("Timeout: o_halt stayed low for 200 cycles after reset release");
                stop_with_failure();
            end
        end while (!o_halt);
    endtask

    // PC parks on the trailing HLT
    task automatic check_end_state();
        check_value("o_pc", NB_DATA'(prog.size() - 1), NB_DATA'(o_pc));
        check_value("o_halt", 16'd1, NB_DATA'(o_halt));
        check_value("o_acc", model_acc, o_acc);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        // Nonzero PC and accumulator left behind before reset
        prog.delete();
        prog.push_back(encode(LDI, 11'h2a5));
        prog.push_back(encode(HLT, '0));
        enter_reset();
        load_program();
        model_program();
        run_program();
        check_end_state();
        // Both must read zero while reset is held
        enter_reset();
        repeat (5) begin
            check_value("o_pc", 16'd0, NB_DATA'(o_pc));
            check_value("o_acc", 16'd0, o_acc);
            check_value("o_halt", 16'd0, NB_DATA'(o_halt));
            @(negedge i_clk);
        end
    endtask

    task automatic test_immediates();
        logic [NB_OPERAND-1:0] imm;
        int                    pick;
        prog.delete();
        imm = NB_OPERAND'($random(seed));
        prog.push_back(encode(LDI, imm));
        for (int i = 0; i < 10; i++) begin
            imm  = NB_OPERAND'($random(seed));
            pick = $random(seed);
            if (pick[0]) begin
                prog.push_back(encode(ADDI, imm));
            end else begin
                prog.push_back(encode(SUBI, imm));
            end
        end
        prog.push_back(encode(HLT, '0));
        enter_reset();
        load_program();
        model_program();
        run_program();
        check_end_state();
    endtask

    task automatic test_memory();
        prog.delete();
        prog.push_back(encode(LDI, NB_OPERAND'($random(seed))));
        prog.push_back(encode(STO, 11'd10));
        prog.push_back(encode(LDI, NB_OPERAND'($random(seed))));
        prog.push_back(encode(STO, 11'd20));
        prog.push_back(encode(ADDI, NB_OPERAND'($random(seed))));
        prog.push_back(encode(STO, 11'd2047));
        prog.push_back(encode(LD, 11'd10));
        prog.push_back(encode(ADD, 11'd20));
        prog.push_back(encode(SUB, 11'd2047));
        prog.push_back(encode(ADD, 11'd10));
        prog.push_back(encode(HLT, '0));
        enter_reset();
        load_program();
        model_program();
        run_program();
        check_end_state();
    endtask

    task automatic test_halt();
        prog.delete();
        prog.push_back(encode(LDI, 11'd7));
        prog.push_back(encode(ADDI, 11'd3));
        prog.push_back(encode(STO, 11'd40));
        prog.push_back(encode(SUBI, 11'd1));
        prog.push_back(encode(ADD, 11'd40));
        prog.push_back(encode(HLT, '0));
        enter_reset();
        load_program();
        model_program();
        run_program();
        check_end_state();
        // Core must stay parked
        repeat (20) begin
            @(negedge i_clk);
            check_value("o_pc", 16'd5, NB_DATA'(o_pc));
            check_value("o_halt", 16'd1, NB_DATA'(o_halt));
            check_value("o_acc", model_acc, o_acc);
        end
    endtask

    task automatic test_stepping();
        int n;
        prog.delete();
        prog.push_back(encode(LDI, NB_OPERAND'($random(seed))));
        prog.push_back(encode(ADDI, NB_OPERAND'($random(seed))));
        prog.push_back(encode(STO, 11'd50));
        prog.push_back(encode(SUBI, NB_OPERAND'($random(seed))));
        prog.push_back(encode(ADD, 11'd50));
        prog.push_back(encode(SUB, 11'd50));
        prog.push_back(encode(ADDI, NB_OPERAND'($random(seed))));
        prog.push_back(encode(LD, 11'd50));
        prog.push_back(encode(HLT, '0));
        n = prog.size() - 1;
        enter_reset();
        load_program();
        @(negedge i_clk);
        i_rst = 1'b1;
        // One instruction retires per clock
        for (int k = 1; k <= n; k++) begin
            @(negedge i_clk);
            model_exec(prog[k-1]);
            check_value("o_pc", NB_DATA'(k), NB_DATA'(o_pc));
            check_value("o_acc", model_acc, o_acc);
            check_value("o_halt", (k == n) ? 16'd1 : 16'd0, NB_DATA'(o_halt));
        end
    endtask

    task automatic test_reload();
        // First program leaves two words behind
        prog.delete();
        prog.push_back(encode(LDI, NB_OPERAND'($random(seed))));
        prog.push_back(encode(STO, 11'd100));
        prog.push_back(encode(LDI, NB_OPERAND'($random(seed))));
        prog.push_back(encode(STO, 11'd101));
        prog.push_back(encode(HLT, '0));
        enter_reset();
        load_program();
        model_program();
        run_program();
        check_end_state();
        // Second program reads them back
        prog.delete();
        prog.push_back(encode(LD, 11'd100));
        prog.push_back(encode(SUB, 11'd101));
        prog.push_back(encode(ADDI, NB_OPERAND'($random(seed))));
        prog.push_back(encode(HLT, '0));
        enter_reset();
        load_program();
        model_program();
        run_program();
        check_end_state();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed        = 36;
        i_rst       = 1'b0;
        i_prog_we   = 1'b0;
        i_prog_addr = '0;
        i_prog_data = '0;
        model_acc   = '0;
        test_reset();
        test_immediates();
        test_memory();
        test_halt();
        test_stepping();
        test_reload();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
